// File: core_pkg.sv
// Shared definitions for the RV32I core
// Data width, major opcodes, ALU operations, immediate formats,
// write-back sources and target adder bases

package core_pkg;

    localparam int XLEN = 32;

    // Major opcodes the core executes
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_t;

    // Write-back value selection
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4,
        WB_TARGET
    } wb_src_t;

    // Second adder base, rs1 only for JALR
    typedef enum logic {
        TGT_PC,
        TGT_RS1
    } tgt_base_t;

endpackage

// File: core_decode.sv
// Control unit and immediate generator
// One instruction word in, control signals and a sign-extended immediate out

`timescale 1ns/10ps

module core_decode (
    input  logic [31:0]         i_instr,
    output core_pkg::alu_op_t   o_alu_op,
    output logic [31:0]         o_imm,
    output logic                o_alu_use_imm,
    output logic                o_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_branch,
    output logic                o_jump,
    output core_pkg::tgt_base_t o_tgt_base,
    output core_pkg::wb_src_t   o_wb_src,
    output logic [2:0]          o_funct3,
    output logic [4:0]          o_rs1,
    output logic [4:0]          o_rs2,
    output logic [4:0]          o_rd
);

    import core_pkg::*;

    opcode_t  opcode;
    imm_fmt_t imm_fmt;
    logic     alt_bit;

    // Operation from funct3, bit 30 picks SUB and SRA
    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt,
                                                input logic is_reg);
        alu_op_t op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode   = opcode_t'(i_instr[6:0]);
    assign alt_bit  = i_instr[30];
    assign o_funct3 = i_instr[14:12];
    assign o_rs2    = i_instr[24:20];
    assign o_rd     = i_instr[11:7];

    // LUI adds its immediate to x0
    assign o_rs1 = (opcode == OP_LUI) ? 5'd0 : i_instr[19:15];

    always_comb begin
        o_alu_op      = ALU_ADD;
        imm_fmt       = IMM_I;
        o_alu_use_imm = 1'b0;
        o_reg_write   = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        o_branch      = 1'b0;
        o_jump        = 1'b0;
        o_tgt_base    = TGT_PC;
        o_wb_src      = WB_ALU;
        case (opcode)
            OP_LUI: begin
                imm_fmt       = IMM_U;
                o_alu_use_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            OP_AUIPC: begin
                imm_fmt     = IMM_U;
                o_reg_write = 1'b1;
                o_wb_src    = WB_TARGET;
            end
            OP_JAL: begin
                imm_fmt     = IMM_J;
                o_jump      = 1'b1;
                o_reg_write = 1'b1;
                o_wb_src    = WB_PC4;
            end
            OP_JALR: begin
                o_jump      = 1'b1;
                o_tgt_base  = TGT_RS1;
                o_reg_write = 1'b1;
                o_wb_src    = WB_PC4;
            end
            OP_BRANCH: begin
                imm_fmt  = IMM_B;
                o_branch = 1'b1;
            end
            OP_LOAD: begin
                o_alu_use_imm = 1'b1;
                o_mem_read    = 1'b1;
                o_reg_write   = 1'b1;
                o_wb_src      = WB_LOAD;
            end
            OP_STORE: begin
                imm_fmt       = IMM_S;
                o_alu_use_imm = 1'b1;
                o_mem_write   = 1'b1;
            end
            OP_IMM: begin
                o_alu_op      = alu_from_funct3(o_funct3, alt_bit, 1'b0);
                o_alu_use_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            OP_REG: begin
                o_alu_op    = alu_from_funct3(o_funct3, alt_bit, 1'b1);
                o_reg_write = 1'b1;
            end
            // Unknown opcode falls through as a no-op
            default: ;
        endcase
    end

    always_comb begin
        case (imm_fmt)
            IMM_S:   o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B:   o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                              i_instr[30:25], i_instr[11:8], 1'b0};
            IMM_U:   o_imm = {i_instr[31:12], 12'b0};
            IMM_J:   o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                              i_instr[20], i_instr[30:21], 1'b0};
            default: o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

endmodule

// File: core_execute.sv
// ALU, branch comparison, target adder and next-PC selection

`timescale 1ns/10ps

module core_execute (
    input  logic [core_pkg::XLEN-1:0] i_pc,
    input  logic [core_pkg::XLEN-1:0] i_rs1_val,
    input  logic [core_pkg::XLEN-1:0] i_rs2_val,
    input  logic [core_pkg::XLEN-1:0] i_imm,
    input  core_pkg::alu_op_t         i_alu_op,
    input  logic                      i_alu_use_imm,
    input  logic                      i_branch,
    input  logic                      i_jump,
    input  logic [2:0]                i_funct3,
    input  core_pkg::tgt_base_t       i_tgt_base,
    output logic [core_pkg::XLEN-1:0] o_alu_result,
    output logic [core_pkg::XLEN-1:0] o_target,
    output logic [core_pkg::XLEN-1:0] o_next_pc
);

    import core_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            branch_taken;
    logic [XLEN-1:0] tgt_base_val;

    assign op_b        = i_alu_use_imm ? i_imm : i_rs2_val;
    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(i_rs1_val) < $signed(op_b);
    assign lt_unsigned = i_rs1_val < op_b;

    always_comb begin
        case (i_alu_op)
            ALU_ADD:  o_alu_result = i_rs1_val + op_b;
            ALU_SUB:  o_alu_result = i_rs1_val - op_b;
            ALU_AND:  o_alu_result = i_rs1_val & op_b;
            ALU_OR:   o_alu_result = i_rs1_val | op_b;
            ALU_XOR:  o_alu_result = i_rs1_val ^ op_b;
            ALU_SLT:  o_alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: o_alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:  o_alu_result = i_rs1_val << shamt;
            ALU_SRL:  o_alu_result = i_rs1_val >> shamt;
            ALU_SRA:  o_alu_result = $signed(i_rs1_val) >>> shamt;
            default:  o_alu_result = '0;
        endcase
    end

    // Branches always compare rs1 with rs2, op_b is rs2 here
    always_comb begin
        case (i_funct3)
            3'b000:  branch_taken = (i_rs1_val == i_rs2_val);
            3'b001:  branch_taken = (i_rs1_val != i_rs2_val);
            3'b100:  branch_taken = lt_signed;
            3'b101:  branch_taken = !lt_signed;
            3'b110:  branch_taken = lt_unsigned;
            3'b111:  branch_taken = !lt_unsigned;
            default: branch_taken = 1'b0;
        endcase
    end

    assign tgt_base_val = (i_tgt_base == TGT_RS1) ? i_rs1_val : i_pc;
    assign o_target     = tgt_base_val + i_imm;

    // Bit 0 cleared for the JALR case
    assign o_next_pc = (i_jump || (i_branch && branch_taken)) ? {o_target[XLEN-1:1], 1'b0}
                                                               : i_pc + 32'd4;

endmodule

// File: core_result.sv
// Store lane alignment and byte enables
// Load byte/half extraction with sign or zero extension
// Write-back source multiplexer

`timescale 1ns/10ps

module core_result (
    input  logic [2:0]                i_funct3,
    input  logic [1:0]                i_addr_low,
    input  logic [core_pkg::XLEN-1:0] i_store_val,
    input  logic [core_pkg::XLEN-1:0] i_load_word,
    input  logic [core_pkg::XLEN-1:0] i_alu_result,
    input  logic [core_pkg::XLEN-1:0] i_pc_plus4,
    input  logic [core_pkg::XLEN-1:0] i_target,
    input  core_pkg::wb_src_t         i_wb_src,
    output logic [3:0]                o_be,
    output logic [core_pkg::XLEN-1:0] o_wdata,
    output logic [core_pkg::XLEN-1:0] o_wb_data
);

    import core_pkg::*;

    logic [XLEN-1:0] load_shifted;
    logic [XLEN-1:0] load_val;

    // Size in funct3[1:0], byte 00, half 01, word 10
    always_comb begin
        case (i_funct3[1:0])
            2'b00: begin
                o_be    = 4'b0001 << i_addr_low;
                o_wdata = i_store_val << {i_addr_low, 3'b000};
            end
            2'b01: begin
                o_be    = i_addr_low[1] ? 4'b1100 : 4'b0011;
                o_wdata = i_store_val << {i_addr_low[1], 4'b0000};
            end
            2'b10: begin
                o_be    = 4'b1111;
                o_wdata = i_store_val;
            end
            default: begin
                o_be    = 4'b0000;
                o_wdata = i_store_val;
            end
        endcase
    end

    // Addressed lane moved down to bit 0
    assign load_shifted = i_load_word >> {i_addr_low, 3'b000};

    always_comb begin
        case (i_funct3)
            3'b000:  load_val = {{24{load_shifted[7]}}, load_shifted[7:0]};
            3'b001:  load_val = {{16{load_shifted[15]}}, load_shifted[15:0]};
            3'b100:  load_val = {24'b0, load_shifted[7:0]};
            3'b101:  load_val = {16'b0, load_shifted[15:0]};
            default: load_val = i_load_word;
        endcase
    end

    always_comb begin
        case (i_wb_src)
            WB_LOAD:   o_wb_data = load_val;
            WB_PC4:    o_wb_data = i_pc_plus4;
            WB_TARGET: o_wb_data = i_target;
            default:   o_wb_data = i_alu_result;
        endcase
    end

endmodule

// File: core_regfile.sv
// Register file, 32 registers of XLEN bits
// Two combinational read ports, one write port, x0 stays zero

`timescale 1ns/10ps

module core_regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_we,
    input  logic [4:0]                i_waddr,
    input  logic [4:0]                i_raddr1,
    input  logic [4:0]                i_raddr2,
    input  logic [core_pkg::XLEN-1:0] i_wdata,
    output logic [core_pkg::XLEN-1:0] o_rdata1,
    output logic [core_pkg::XLEN-1:0] o_rdata2
);

    import core_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != 5'd0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Old value visible during the write cycle
    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

endmodule

// File: core_top.sv
// Single-cycle RV32I core top
// Program counter, stall logic, data port request and block instances

`timescale 1ns/10ps

module core_top #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               i_imem_rdata,
    input  logic                      i_imem_valid,
    output logic [core_pkg::XLEN-1:0] o_imem_addr,
    output logic                      o_dmem_valid,
    output logic                      o_dmem_write,
    output logic [core_pkg::XLEN-1:0] o_dmem_addr,
    output logic [3:0]                o_dmem_be,
    output logic [core_pkg::XLEN-1:0] o_dmem_wdata,
    input  logic                      i_dmem_ready,
    input  logic [core_pkg::XLEN-1:0] i_dmem_rdata
);

    import core_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic            stall;

    alu_op_t         alu_op;
    tgt_base_t       tgt_base;
    wb_src_t         wb_src;
    logic [XLEN-1:0] imm;
    logic            alu_use_imm;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic            branch;
    logic            jump;
    logic [2:0]      funct3;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] wb_data;

    assign o_imem_addr = pc;
    assign pc_plus4    = pc + 32'd4;

    // Fetch valid qualifies the data request
    assign o_dmem_valid = i_imem_valid && (mem_read || mem_write);
    assign o_dmem_write = mem_write;
    assign o_dmem_addr  = {alu_result[XLEN-1:2], 2'b00};

    // Missing instruction or data access still waiting
    assign stall = !i_imem_valid || (o_dmem_valid && !i_dmem_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    core_decode u_decode (
        .i_instr       (i_imem_rdata),
        .o_alu_op      (alu_op),
        .o_imm         (imm),
        .o_alu_use_imm (alu_use_imm),
        .o_reg_write   (reg_write),
        .o_mem_read    (mem_read),
        .o_mem_write   (mem_write),
        .o_branch      (branch),
        .o_jump        (jump),
        .o_tgt_base    (tgt_base),
        .o_wb_src      (wb_src),
        .o_funct3      (funct3),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .o_rd          (rd)
    );

    core_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_we     (reg_write && !stall),
        .i_waddr  (rd),
        .i_raddr1 (rs1),
        .i_raddr2 (rs2),
        .i_wdata  (wb_data),
        .o_rdata1 (rs1_val),
        .o_rdata2 (rs2_val)
    );

    core_execute u_execute (
        .i_pc          (pc),
        .i_rs1_val     (rs1_val),
        .i_rs2_val     (rs2_val),
        .i_imm         (imm),
        .i_alu_op      (alu_op),
        .i_alu_use_imm (alu_use_imm),
        .i_branch      (branch),
        .i_jump        (jump),
        .i_funct3      (funct3),
        .i_tgt_base    (tgt_base),
        .o_alu_result  (alu_result),
        .o_target      (target),
        .o_next_pc     (next_pc)
    );

    core_result u_result (
        .i_funct3     (funct3),
        .i_addr_low   (alu_result[1:0]),
        .i_store_val  (rs2_val),
        .i_load_word  (i_dmem_rdata),
        .i_alu_result (alu_result),
        .i_pc_plus4   (pc_plus4),
        .i_target     (target),
        .i_wb_src     (wb_src),
        .o_be         (o_dmem_be),
        .o_wdata      (o_dmem_wdata),
        .o_wb_data    (wb_data)
    );

    // Request held steady under back-pressure
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        o_dmem_valid && !i_dmem_ready |=>
            $stable(o_dmem_addr) && $stable(o_dmem_write) &&
            $stable(o_dmem_be) && $stable(o_dmem_wdata))
        else $error("data request changed while waiting for ready");

    // Halfword accesses stay inside one aligned half
    a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        o_dmem_valid && (funct3[1:0] == 2'b01) |-> !alu_result[0])
        else $error("misaligned halfword access");

endmodule

// File: tb_core_mem.sv
// Memory models for the core testbench
// tb_imem: instruction ROM with the test program and a gated valid
// tb_dmem: 256-word data RAM with byte enables and a gated ready

`timescale 1ns/10ps

module tb_imem #(
    parameter logic [31:0] BASE = 32'h0000_0100
) (
    input  logic        i_en,
    input  logic        i_gap,
    input  logic [31:0] i_addr,
    output logic        o_valid,
    output logic [31:0] o_rdata
);

    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_OP    = 7'b0110011;

    logic [31:0] rom [128];
    logic [31:0] word_idx;
    int          n;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic put(input logic [31:0] word);
        rom[n] = word;
        n++;
    endtask

    // Taken branch skips a store of zero to 0x3F8, not-taken stores x1
    task automatic branch_pair(input logic [2:0] f3, input logic [4:0] ta, input logic [4:0] tb,
                               input logic [4:0] na, input logic [4:0] nb,
                               input logic [11:0] slot);
        put(enc_b(13'd8, tb, ta, f3));
        put(enc_s(12'h3F8, 5'd0, 5'd0, 3'd2));
        put(enc_b(13'd8, nb, na, f3));
        put(enc_s(slot, 5'd1, 5'd0, 3'd2));
    endtask

    initial begin
        n = 0;
        for (int i = 0; i < 128; i++) begin
            rom[i] = 32'h0;
        end
        put(enc_i(12'h123, 5'd0, 3'd0, 5'd1, OPC_OPIMM));
        put(enc_i(12'hFFB, 5'd0, 3'd0, 5'd2, OPC_OPIMM));
        // Custom opcode with rd = x1, must not write
        put(32'h0000_008B);
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        put(enc_s(12'h000, 5'd3, 5'd0, 3'd2));
        put(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
        put(enc_s(12'h004, 5'd3, 5'd0, 3'd2));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd3));
        put(enc_s(12'h008, 5'd3, 5'd0, 3'd2));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd3));
        put(enc_s(12'h00C, 5'd3, 5'd0, 3'd2));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd3));
        put(enc_s(12'h010, 5'd3, 5'd0, 3'd2));
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd3));
        put(enc_s(12'h014, 5'd3, 5'd0, 3'd2));
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd3));
        put(enc_s(12'h018, 5'd3, 5'd0, 3'd2));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd3));
        put(enc_s(12'h01C, 5'd3, 5'd0, 3'd2));
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd5, 5'd3));
        put(enc_s(12'h020, 5'd3, 5'd0, 3'd2));
        put(enc_i(12'h401, 5'd2, 3'd5, 5'd3, OPC_OPIMM));
        put(enc_s(12'h024, 5'd3, 5'd0, 3'd2));
        put(enc_i(12'h004, 5'd1, 3'd1, 5'd3, OPC_OPIMM));
        put(enc_s(12'h028, 5'd3, 5'd0, 3'd2));
        put({20'hABCDE, 5'd3, OPC_LUI});
        put(enc_s(12'h02C, 5'd3, 5'd0, 3'd2));
        put({20'h00001, 5'd3, OPC_AUIPC});
        put(enc_s(12'h030, 5'd3, 5'd0, 3'd2));
        // x4 = 0x123456F8 for the sub-word stores
        put({20'h12345, 5'd4, OPC_LUI});
        put(enc_i(12'h6F8, 5'd4, 3'd0, 5'd4, OPC_OPIMM));
        for (int k = 0; k < 4; k++) begin
            put(enc_s(12'h040 + 12'(k), 5'd4, 5'd0, 3'd0));
        end
        put(enc_s(12'h044, 5'd4, 5'd0, 3'd1));
        put(enc_s(12'h046, 5'd4, 5'd0, 3'd1));
        put(enc_i(12'h201, 5'd0, 3'd0, 5'd5, OPC_LOAD));
        put(enc_s(12'h060, 5'd5, 5'd0, 3'd2));
        put(enc_i(12'h201, 5'd0, 3'd4, 5'd5, OPC_LOAD));
        put(enc_s(12'h064, 5'd5, 5'd0, 3'd2));
        put(enc_i(12'h202, 5'd0, 3'd1, 5'd5, OPC_LOAD));
        put(enc_s(12'h068, 5'd5, 5'd0, 3'd2));
        put(enc_i(12'h202, 5'd0, 3'd5, 5'd5, OPC_LOAD));
        put(enc_s(12'h06C, 5'd5, 5'd0, 3'd2));
        put(enc_i(12'h200, 5'd0, 3'd2, 5'd5, OPC_LOAD));
        put(enc_s(12'h070, 5'd5, 5'd0, 3'd2));
        put(enc_i(12'h043, 5'd0, 3'd0, 5'd5, OPC_LOAD));
        put(enc_s(12'h074, 5'd5, 5'd0, 3'd2));
        put(enc_i(12'h046, 5'd0, 3'd5, 5'd5, OPC_LOAD));
        put(enc_s(12'h078, 5'd5, 5'd0, 3'd2));
        // x1 = 0x123, x2 = -5
        branch_pair(3'd0, 5'd1, 5'd1, 5'd1, 5'd2, 12'h080);
        branch_pair(3'd1, 5'd1, 5'd2, 5'd1, 5'd1, 12'h084);
        branch_pair(3'd4, 5'd2, 5'd1, 5'd1, 5'd2, 12'h088);
        branch_pair(3'd5, 5'd1, 5'd2, 5'd2, 5'd1, 12'h08C);
        branch_pair(3'd6, 5'd1, 5'd2, 5'd2, 5'd1, 12'h090);
        branch_pair(3'd7, 5'd2, 5'd1, 5'd1, 5'd2, 12'h094);
        put(enc_j(21'd8, 5'd7));
        put(enc_s(12'h3F8, 5'd0, 5'd0, 3'd2));
        put(enc_s(12'h098, 5'd7, 5'd0, 3'd2));
        put({20'h00000, 5'd6, OPC_AUIPC});
        // Odd target, bit 0 gets cleared by the jump
        put(enc_i(12'd17, 5'd6, 3'd0, 5'd6, OPC_OPIMM));
        put(enc_i(12'd0, 5'd6, 3'd0, 5'd8, OPC_JALR));
        put(enc_s(12'h3F8, 5'd0, 5'd0, 3'd2));
        put(enc_s(12'h09C, 5'd8, 5'd0, 3'd2));
        put(enc_s(12'h3FC, 5'd1, 5'd0, 3'd2));
        put(enc_j(21'd0, 5'd0));
    end

    assign word_idx = (i_addr - BASE) >> 2;
    assign o_rdata  = (word_idx < 128) ? rom[word_idx[6:0]] : 32'h0;
    assign o_valid  = i_en && !i_gap;

endmodule

module tb_dmem (
    input  logic        clk,
    input  logic        i_valid,
    input  logic        i_write,
    input  logic [31:0] i_addr,
    input  logic [3:0]  i_be,
    input  logic [31:0] i_wdata,
    input  logic        i_hold,
    output logic        o_ready,
    output logic [31:0] o_rdata
);

    logic [31:0] mem [256];

    // Every byte of the pattern depends on the word index
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5A, idx ^ 8'h80};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(8'(i));
        end
    end

    assign o_ready = !i_hold;
    assign o_rdata = mem[i_addr[9:2]];

    always @(posedge clk) begin
        if (i_valid && o_ready && i_write) begin
            for (int b = 0; b < 4; b++) begin
                if (i_be[b]) begin
                    mem[i_addr[9:2]][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: tb_core.sv
// Testbench for the RV32I core
// Clock, reset, LFSR-driven fetch gaps and back-pressure,
// expected store trace, assertions, timeout and closing report

`timescale 1ns/10ps

module tb_core;

    localparam logic [31:0] RESET_PC     = 32'h0000_0100;
    localparam int          PROG_LEN     = 85;
    localparam int          STALL_FACTOR = 8;
    localparam int          TIMEOUT      = PROG_LEN * STALL_FACTOR + 20;

    logic        clk;
    logic        rst_n;
    logic        imem_gap;
    logic        dmem_hold;
    logic [31:0] imem_rdata;
    logic        imem_valid;
    logic [31:0] imem_addr;
    logic        dmem_valid;
    logic        dmem_write;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_be;
    logic [31:0] dmem_wdata;
    logic        dmem_ready;
    logic [31:0] dmem_rdata;

    logic [31:0] lfsr;
    logic [31:0] exp_addr [64];
    logic [3:0]  exp_be [64];
    logic [31:0] exp_data [64];
    logic [31:0] fw;
    int          n_exp;
    int          store_idx;
    int          cycles;
    int          errors;
    int          rst_cnt;
    logic        done;
    logic        store_fire;
    logic        retire;
    logic        is_ctrl;
    logic        is_mem;
    logic [31:0] exp_pc;

    core_top #(.RESET_PC(RESET_PC)) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_imem_rdata (imem_rdata),
        .i_imem_valid (imem_valid),
        .o_imem_addr  (imem_addr),
        .o_dmem_valid (dmem_valid),
        .o_dmem_write (dmem_write),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_be    (dmem_be),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_ready (dmem_ready),
        .i_dmem_rdata (dmem_rdata)
    );

    tb_imem #(.BASE(RESET_PC)) u_imem (
        .i_en    (rst_n),
        .i_gap   (imem_gap),
        .i_addr  (imem_addr),
        .o_valid (imem_valid),
        .o_rdata (imem_rdata)
    );

    tb_dmem u_dmem (
        .clk     (clk),
        .i_valid (dmem_valid),
        .i_write (dmem_write),
        .i_addr  (dmem_addr),
        .i_be    (dmem_be),
        .i_wdata (dmem_wdata),
        .i_hold  (dmem_hold),
        .o_ready (dmem_ready),
        .o_rdata (dmem_rdata)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] be_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic add_exp(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data);
        exp_addr[n_exp] = addr;
        exp_be[n_exp]   = be;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    // Next fetch address after a jump or branch of the test program
    function automatic logic [31:0] ctrl_next_pc(input logic [31:0] pc);
        logic [31:0] off;
        off = pc - RESET_PC;
        if (off == 32'h140) begin
            // JALR to the AUIPC value plus 17, bit 0 cleared
            return (RESET_PC + 32'h138 + 32'd17) & ~32'd1;
        end
        if (off == 32'h150) begin
            return pc;
        end
        // First branch of each pair and the JAL skip one word
        if (off[3:0] == 4'hC) begin
            return pc + 32'd8;
        end
        return pc + 32'd4;
    endfunction

    assign store_fire = dmem_valid && dmem_write && dmem_ready;
    assign is_mem     = (imem_rdata[6:0] == 7'h03) || (imem_rdata[6:0] == 7'h23);
    assign retire     = imem_valid && (!is_mem || dmem_ready);
    assign is_ctrl    = (imem_rdata[6:0] == 7'h6F) || (imem_rdata[6:0] == 7'h67) ||
                        (imem_rdata[6:0] == 7'h63);
    assign exp_pc     = is_ctrl ? ctrl_next_pc(imem_addr) : imem_addr + 32'd4;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        lfsr      = 32'h7521_fef2;
        rst_n     = 1'b0;
        imem_gap  = 1'b0;
        dmem_hold = 1'b0;
        rst_cnt   = 0;
        cycles    = 0;
        store_idx = 0;
        done      = 1'b0;
        n_exp     = 0;
        errors    = 0;
        // Fill word of RAM word 0x80, untouched before the loads
        fw        = 32'h807F_DA00;
        add_exp(32'h00, 4'hF, 32'h123 + 32'hFFFF_FFFB);
        add_exp(32'h04, 4'hF, 32'h123 - 32'hFFFF_FFFB);
        add_exp(32'h08, 4'hF, 32'h123 & 32'hFFFF_FFFB);
        add_exp(32'h0C, 4'hF, 32'h123 | 32'hFFFF_FFFB);
        add_exp(32'h10, 4'hF, 32'h123 ^ 32'hFFFF_FFFB);
        add_exp(32'h14, 4'hF, 32'h1);
        add_exp(32'h18, 4'hF, 32'h0);
        add_exp(32'h1C, 4'hF, 32'h123 << 27);
        add_exp(32'h20, 4'hF, 32'hFFFF_FFFB >> 3);
        add_exp(32'h24, 4'hF, 32'hFFFF_FFFD);
        add_exp(32'h28, 4'hF, 32'h1230);
        add_exp(32'h2C, 4'hF, 32'hABCD_E000);
        add_exp(32'h30, 4'hF, 32'h16C + 32'h1000);
        add_exp(32'h40, 4'b0001, 32'h0000_00F8);
        add_exp(32'h40, 4'b0010, 32'h0000_F800);
        add_exp(32'h40, 4'b0100, 32'h00F8_0000);
        add_exp(32'h40, 4'b1000, 32'hF800_0000);
        add_exp(32'h44, 4'b0011, 32'h0000_56F8);
        add_exp(32'h44, 4'b1100, 32'h56F8_0000);
        add_exp(32'h60, 4'hF, {{24{fw[15]}}, fw[15:8]});
        add_exp(32'h64, 4'hF, {24'h0, fw[15:8]});
        add_exp(32'h68, 4'hF, {{16{fw[31]}}, fw[31:16]});
        add_exp(32'h6C, 4'hF, {16'h0, fw[31:16]});
        add_exp(32'h70, 4'hF, fw);
        add_exp(32'h74, 4'hF, 32'hFFFF_FFF8);
        add_exp(32'h78, 4'hF, 32'h0000_56F8);
        for (int k = 0; k < 6; k++) begin
            add_exp(32'h80 + 32'(4 * k), 4'hF, 32'h123);
        end
        // Link values, old PC plus four
        add_exp(32'h98, 4'hF, 32'h230);
        add_exp(32'h9C, 4'hF, 32'h244);
        add_exp(32'h3FC, 4'hF, 32'h123);

        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
        end
        @(posedge clk);
        if (!done) begin
            errors++;
            $display("Timeout after %0d cycles without reaching the marker store", cycles);
        end
        if (store_idx != n_exp) begin
            errors++;
            $display("Saw %0d stores but expected %0d", store_idx, n_exp);
        end
        $display("Errors: %0d, stores checked: %0d", errors, store_idx);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Reset count, random fetch gaps (1 in 4) and back-pressure (1 in 2)
    always @(posedge clk) begin
        logic b0;
        logic b1;
        logic b2;
        lfsr = lfsr_next(lfsr);
        b0 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b2 = lfsr[0];
        imem_gap  <= b0 && b1;
        dmem_hold <= b2;
        if (rst_cnt < 3) begin
            rst_cnt <= rst_cnt + 1;
        end else begin
            rst_n <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n && store_fire) begin
            store_idx <= store_idx + 1;
            if (dmem_addr == 32'h3FC) begin
                done <= 1'b1;
            end
        end
    end

    a_reset_pc: assert property (@(posedge clk)
        (rst_cnt > 0 && !rst_n) || $rose(rst_n) |-> imem_addr == RESET_PC && !dmem_valid)
        else begin
            errors++;
            $display("Error: %0t o_imem_addr expected %h got %h or o_dmem_valid high in reset",
                     $time, RESET_PC, $sampled(imem_addr));
        end

    a_store_count: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire |-> store_idx < n_exp)
        else begin
            errors++;
            $display("Store beyond the end of the expected trace");
        end

    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire && store_idx < n_exp |-> dmem_addr == exp_addr[store_idx])
        else begin
            errors++;
            $display("Error: %0t o_dmem_addr expected %h got %h", $time,
                     exp_addr[$sampled(store_idx)], $sampled(dmem_addr));
        end

    a_store_be: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire && store_idx < n_exp |-> dmem_be == exp_be[store_idx])
        else begin
            errors++;
            $display("Error: %0t o_dmem_be expected %b got %b", $time,
                     exp_be[$sampled(store_idx)], $sampled(dmem_be));
        end

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire && store_idx < n_exp |->
            (dmem_wdata & be_mask(exp_be[store_idx])) ==
            (exp_data[store_idx] & be_mask(exp_be[store_idx])))
        else begin
            errors++;
            $display("Error: %0t o_dmem_wdata expected %h got %h", $time,
                     exp_data[$sampled(store_idx)], $sampled(dmem_wdata));
        end

    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !retire |=> $stable(imem_addr))
        else begin
            errors++;
            $display("PC moved while the instruction was missing or a data access waited");
        end

    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        retire |=> imem_addr == $past(exp_pc))
        else begin
            errors++;
            $display("Error: %0t o_imem_addr expected %h got %h", $time,
                     $past(exp_pc), $sampled(imem_addr));
        end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid && !dmem_ready |=>
            $stable(dmem_addr) && $stable(dmem_be) && $stable(dmem_wdata) &&
            $stable(dmem_write))
        else begin
            errors++;
            $display("Data request fields changed while waiting for ready");
        end

endmodule

// File: list.f
core_pkg.sv
core_decode.sv
core_execute.sv
core_result.sv
core_regfile.sv
core_top.sv
tb_core_mem.sv
tb_core.sv
